// File: include/rtc_params.svh
`ifndef RTC_PARAMS_SVH
`define RTC_PARAMS_SVH

// processor port ids
`define RTC_PORT_ADDR   8'd12
`define RTC_PORT_CTRL   8'd13
`define RTC_PORT_WDATA  8'd15
`define RTC_PORT_STATUS 8'd1
`define RTC_PORT_RDATA  8'd2

// clocks per bus phase
`define RTC_PHASE_CYCLES 2

// countdown limits in bcd
`define RTC_LIMIT_SEC  8'h59
`define RTC_LIMIT_MIN  8'h59
`define RTC_LIMIT_HOUR 8'h23

`endif

// File: rtl/rtcCpuPortPkg.sv
`default_nettype none

package rtcCpuPortPkg;

  // one byte on both the processor side and the rtc bus
  typedef logic [7:0] byte_t;

  // control port bits
  localparam int CTRL_START_BIT = 0; // request a transfer
  localparam int CTRL_WRITE_BIT = 1; // 1 = write, 0 = read

  // status port bits
  localparam int STAT_DONE_BIT = 0;
  localparam int STAT_IRQ_BIT  = 1;
  localparam int STAT_BUSY_BIT = 2;

endpackage

`default_nettype wire

// File: rtl/rtcBusPkg.sv
`default_nettype none

package rtcBusPkg;

  // multiplexed bus phases, each one lasts RTC_PHASE_CYCLES clocks
  typedef enum logic [2:0] {
    IDLE,
    ADDR_SETUP,
    ADDR_STROBE,
    GAP,
    DATA_STROBE
  } busPhase_t;

  // countdown timer registers, stored as limit minus value in bcd
  localparam rtcCpuPortPkg::byte_t REG_CD_SEC  = 8'h41;
  localparam rtcCpuPortPkg::byte_t REG_CD_MIN  = 8'h42;
  localparam rtcCpuPortPkg::byte_t REG_CD_HOUR = 8'h43;

endpackage

`default_nettype wire

// File: rtl/bcdComplement.sv
`default_nettype none

// result = limit - value, two bcd digits, wraps modulo 100
module bcdComplement (
  input  rtcCpuPortPkg::byte_t limit,
  input  rtcCpuPortPkg::byte_t value,
  output rtcCpuPortPkg::byte_t result
);

  logic [4:0] diffLo;
  logic [4:0] diffHi;
  logic       borrowLo;
  logic [3:0] digitLo;
  logic [3:0] digitHi;

  always_comb begin
    diffLo   = {1'b0, limit[3:0]} - {1'b0, value[3:0]};
    borrowLo = diffLo[4]; // low digit went negative
    // adding ten in four bits fixes up the negative digit
    if (borrowLo) begin
      digitLo = diffLo[3:0] + 4'd10;
    end else begin
      digitLo = diffLo[3:0];
    end

    diffHi = {1'b0, limit[7:4]} - {1'b0, value[7:4]} - {4'b0, borrowLo};
    if (diffHi[4]) begin
      digitHi = diffHi[3:0] + 4'd10; // wrap past zero like a countdown
    end else begin
      digitHi = diffHi[3:0];
    end
  end

  assign result = {digitHi, digitLo};

endmodule

`default_nettype wire

// File: rtl/rtcBusSequencer.sv
`default_nettype none

`include "rtc_params.svh"

module rtcBusSequencer (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic writeOp,
  output logic busy,
  output logic addrPhase,
  output logic dataPhase,
  output logic capture,
  output logic done,
  output logic adN,
  output logic csN,
  output logic rdN,
  output logic wrN
);

  import rtcBusPkg::*;

  localparam int CNT_W = $clog2(`RTC_PHASE_CYCLES + 1);

  busPhase_t        phase;
  logic [CNT_W-1:0] phaseCnt;
  logic             writeLatched;
  logic             phaseEnd;

  assign phaseEnd = (phaseCnt == CNT_W'(`RTC_PHASE_CYCLES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      phase        <= IDLE;
      phaseCnt     <= '0;
      writeLatched <= 1'b0;
      done         <= 1'b0;
    end else begin
      done <= 1'b0;
      if (phase == IDLE) begin
        phaseCnt <= '0;
        if (start) begin // starts while busy never get here
          phase        <= ADDR_SETUP;
          writeLatched <= writeOp;
        end
      end else if (phaseEnd) begin
        phaseCnt <= '0;
        case (phase)
          ADDR_SETUP:  phase <= ADDR_STROBE;
          ADDR_STROBE: phase <= GAP;
          GAP:         phase <= DATA_STROBE;
          default: begin
            phase <= IDLE;
            done  <= 1'b1; // cycle after the last data strobe cycle
          end
        endcase
      end else begin
        phaseCnt <= phaseCnt + 1'b1;
      end
    end
  end

  assign busy = (phase != IDLE);

  // address is on the bus through setup and strobe
  assign addrPhase = (phase == ADDR_SETUP) || (phase == ADDR_STROBE);
  // only writes drive data
  assign dataPhase = (phase == DATA_STROBE) && writeLatched;
  assign capture   = (phase == DATA_STROBE) && phaseEnd && !writeLatched;

  // strobes are active low
  assign csN = (phase == IDLE); // held for the whole transfer
  assign adN = (phase != ADDR_STROBE);
  assign wrN = !((phase == DATA_STROBE) && writeLatched);
  assign rdN = !((phase == DATA_STROBE) && !writeLatched);

endmodule

`default_nettype wire

// File: rtl/rtcPort.sv
`default_nettype none

`include "rtc_params.svh"

module rtcPort (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 readStrobe,
  input  logic                 writeStrobe,
  input  rtcCpuPortPkg::byte_t portId,
  input  rtcCpuPortPkg::byte_t dataIn,
  output rtcCpuPortPkg::byte_t dataOut,
  input  logic                 irq,
  input  rtcCpuPortPkg::byte_t busIn,
  output rtcCpuPortPkg::byte_t busOut,
  output logic                 busOe,
  output logic                 seqStart,
  output logic                 seqWrite,
  input  logic                 seqBusy,
  input  logic                 seqAddrPhase,
  input  logic                 seqDataPhase,
  input  logic                 seqCapture,
  input  logic                 seqDone,
  output rtcCpuPortPkg::byte_t cpLimit,
  input  rtcCpuPortPkg::byte_t txAdjusted,
  input  rtcCpuPortPkg::byte_t rxAdjusted
);

  import rtcCpuPortPkg::*;
  import rtcBusPkg::*;

  byte_t addrReg;
  byte_t wdataReg;
  byte_t rdataReg;
  byte_t statusReg;
  logic  isCountdown;
  logic  statusRd1;
  logic  statusRd2;
  logic  statusRdEnd;
  logic  dataSelect;

  // countdown registers go through the bcd complement units
  assign isCountdown = addrReg inside {REG_CD_SEC, REG_CD_MIN, REG_CD_HOUR};

  always_comb begin
    case (addrReg)
      REG_CD_SEC:  cpLimit = `RTC_LIMIT_SEC;
      REG_CD_MIN:  cpLimit = `RTC_LIMIT_MIN;
      REG_CD_HOUR: cpLimit = `RTC_LIMIT_HOUR;
      default:     cpLimit = 8'h00;
    endcase
  end

  // address is written before data, so the limit is already known here
  always_ff @(posedge clk) begin
    if (writeStrobe && (portId == `RTC_PORT_ADDR)) begin
      addrReg <= dataIn;
    end
    if (writeStrobe && (portId == `RTC_PORT_WDATA)) begin
      wdataReg <= isCountdown ? txAdjusted : dataIn;
    end
    if (seqCapture) begin
      rdataReg <= isCountdown ? rxAdjusted : busIn;
    end
  end

  // start goes out in the cycle of the control write
  assign seqStart = writeStrobe && (portId == `RTC_PORT_CTRL) && dataIn[CTRL_START_BIT];
  assign seqWrite = dataIn[CTRL_WRITE_BIT];

  // falling edge of a status read
  assign statusRdEnd = statusRd2 && !statusRd1;

  always_ff @(posedge clk) begin
    if (rst) begin
      statusReg  <= '0;
      statusRd1  <= 1'b0;
      statusRd2  <= 1'b0;
      dataSelect <= 1'b0;
    end else begin
      statusRd1 <= readStrobe && (portId == `RTC_PORT_STATUS);
      statusRd2 <= statusRd1;
      statusReg[STAT_IRQ_BIT]  <= irq;
      statusReg[STAT_BUSY_BIT] <= seqBusy;
      if (seqDone) begin
        statusReg[STAT_DONE_BIT] <= 1'b1; // a new completion wins over a clear
      end else if (statusRdEnd) begin
        statusReg[STAT_DONE_BIT] <= 1'b0;
      end
      // keep the bus value steady across each rising strobe
      if (seqAddrPhase) begin
        dataSelect <= 1'b0;
      end else if (seqBusy) begin
        dataSelect <= 1'b1;
      end
    end
  end

  always_comb begin
    if (seqAddrPhase) begin
      busOut = addrReg;
    end else if (dataSelect) begin
      busOut = wdataReg;
    end else begin
      busOut = addrReg; // still the address during the first gap edge
    end
  end

  assign busOe = seqAddrPhase || seqDataPhase;

  assign dataOut = (portId == `RTC_PORT_STATUS) ? statusReg : rdataReg;

endmodule

`default_nettype wire

// File: rtl/rtcSubsystem.sv
`default_nettype none

module rtcSubsystem (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 readStrobe,
  input  logic                 writeStrobe,
  input  rtcCpuPortPkg::byte_t portId,
  input  rtcCpuPortPkg::byte_t dataIn,
  output rtcCpuPortPkg::byte_t dataOut,
  input  logic                 irq,
  output logic                 adN,
  output logic                 csN,
  output logic                 rdN,
  output logic                 wrN,
  output rtcCpuPortPkg::byte_t busOut,
  output logic                 busOe,
  input  rtcCpuPortPkg::byte_t busIn
);

  import rtcCpuPortPkg::*;

  logic  seqStart;
  logic  seqWrite;
  logic  seqBusy;
  logic  seqAddrPhase;
  logic  seqDataPhase;
  logic  seqCapture;
  logic  seqDone;
  byte_t cpLimit;
  byte_t txAdjusted;
  byte_t rxAdjusted;

  rtcPort port_i (
    .clk          (clk),
    .rst          (rst),
    .readStrobe   (readStrobe),
    .writeStrobe  (writeStrobe),
    .portId       (portId),
    .dataIn       (dataIn),
    .dataOut      (dataOut),
    .irq          (irq),
    .busIn        (busIn),
    .busOut       (busOut),
    .busOe        (busOe),
    .seqStart     (seqStart),
    .seqWrite     (seqWrite),
    .seqBusy      (seqBusy),
    .seqAddrPhase (seqAddrPhase),
    .seqDataPhase (seqDataPhase),
    .seqCapture   (seqCapture),
    .seqDone      (seqDone),
    .cpLimit      (cpLimit),
    .txAdjusted   (txAdjusted),
    .rxAdjusted   (rxAdjusted)
  );

  rtcBusSequencer sequencer_i (
    .clk       (clk),
    .rst       (rst),
    .start     (seqStart),
    .writeOp   (seqWrite),
    .busy      (seqBusy),
    .addrPhase (seqAddrPhase),
    .dataPhase (seqDataPhase),
    .capture   (seqCapture),
    .done      (seqDone),
    .adN       (adN),
    .csN       (csN),
    .rdN       (rdN),
    .wrN       (wrN)
  );

  // processor data on its way into the write-data register
  bcdComplement txComplement_i (
    .limit  (cpLimit),
    .value  (dataIn),
    .result (txAdjusted)
  );

  // chip data on its way back
  bcdComplement rxComplement_i (
    .limit  (cpLimit),
    .value  (busIn),
    .result (rxAdjusted)
  );

endmodule

`default_nettype wire

// File: tb/rtcChipModel.sv
`default_nettype none

// behavioral rtc chip, 128 byte registers on a multiplexed address/data bus
module rtcChipModel (
  input  logic                 adN,
  input  logic                 csN,
  input  logic                 rdN,
  input  logic                 wrN,
  input  rtcCpuPortPkg::byte_t busOut,
  output rtcCpuPortPkg::byte_t busIn
);

  timeunit 1ns;
  timeprecision 1ps;

  import rtcCpuPortPkg::*;

  byte_t      regs [0:127];
  logic [6:0] addrLatch;
  logic       writeArmed;

  initial begin
    int i;
    addrLatch  = '0;
    writeArmed = 1'b0;
    for (i = 0; i < 128; i++) begin
      regs[i] = 8'(i * 3) ^ 8'h96; // odd multiplier keeps every address distinct
    end
  end

  // address is taken as the strobe goes back high
  always @(posedge adN) begin
    if (csN == 1'b0) begin
      addrLatch <= busOut[6:0];
    end
  end

  always @(negedge wrN) begin
    writeArmed <= 1'b1;
  end

  always @(posedge wrN) begin
    if (writeArmed) begin
      regs[addrLatch] <= busOut;
      writeArmed      <= 1'b0;
    end
  end

  assign busIn = rdN ? 8'h00 : regs[addrLatch]; // drives only during a read strobe

endmodule

`default_nettype wire

// File: tb/rtcSubsystem_sva.sv
`default_nettype none

// bus protocol checks bound into the subsystem top level
module rtcSubsystem_sva (
  input logic clk,
  input logic rst,
  input logic adN,
  input logic csN,
  input logic rdN,
  input logic wrN,
  input logic busOe,
  input logic capture,
  input logic done
);

  timeunit 1ns;
  timeprecision 1ps;

  strobeNeedsSelect: assert property (@(posedge clk) disable iff (rst)
    (!adN || !rdN || !wrN) |-> !csN)
    else $error("address, read or write strobe low without chip select");

  noDriveDuringRead: assert property (@(posedge clk) disable iff (rst)
    !rdN |-> !busOe)
    else $error("bus output enabled while the chip drives read data");

  // the chip latches whatever the port drives under these strobes
  strobeHasDrive: assert property (@(posedge clk) disable iff (rst)
    (!adN || !wrN) |-> busOe)
    else $error("address or write strobe low with the bus output disabled");

  readWriteExclusive: assert property (@(posedge clk) disable iff (rst)
    rdN || wrN)
    else $error("read and write strobes low together");

  captureInRead: assert property (@(posedge clk) disable iff (rst)
    capture |-> !rdN)
    else $error("capture outside a read strobe");

  donePulse: assert property (@(posedge clk) disable iff (rst)
    done |=> !done)
    else $error("done pulse longer than one cycle");

endmodule

`default_nettype wire

// File: tb/rtcSubsystem_tb.sv
`default_nettype none

`include "rtc_params.svh"

module rtcSubsystem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import rtcCpuPortPkg::*;

  localparam byte_t START_READ  = byte_t'(1 << CTRL_START_BIT);
  localparam byte_t START_WRITE = byte_t'((1 << CTRL_START_BIT) | (1 << CTRL_WRITE_BIT));

  logic  clk = 1'b0;
  logic  rst;
  logic  readStrobe;
  logic  writeStrobe;
  byte_t portId;
  byte_t dataIn;
  byte_t dataOut;
  logic  irq;
  logic  adN;
  logic  csN;
  logic  rdN;
  logic  wrN;
  byte_t busOut;
  logic  busOe;
  byte_t busIn;

  logic [7:0]  opQ[$];
  byte_t       addrQ[$];
  byte_t       valueQ[$];
  byte_t       expectQ[$];
  logic [31:0] lfsrState = 32'hb976c2d1;
  int          cycleLimit = 0;
  int          cycleCount = 0;

  rtcSubsystem dut_i (.*);
  rtcChipModel chip_i (.*);

  bind rtcSubsystem rtcSubsystem_sva sva_i (
    .clk, .rst, .adN, .csN, .rdN, .wrN, .busOe,
    .capture (seqCapture),
    .done    (seqDone)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]}; // taps 32 22 2 1
  endfunction

  task automatic takeBits(input int count, output int bits);
    int i;
    bits = 0;
    for (i = 0; i < count; i++) begin
      lfsrState = lfsrStep(lfsrState);
      bits      = (bits << 1) | int'(lfsrState[0]);
    end
  endtask

  task automatic checkValue(input string testName, input byte_t expected, input byte_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected 0x%02h actual 0x%02h", testName, expected, actual);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  task automatic nextDrivePoint();
    @(posedge clk);
    #1;
  endtask

  task automatic writePort(input byte_t id, input byte_t data);
    portId      = id;
    dataIn      = data;
    writeStrobe = 1'b1;
    nextDrivePoint();
    writeStrobe = 1'b0;
  endtask

  task automatic readPort(input byte_t id, output byte_t data);
    portId     = id;
    readStrobe = 1'b1;
    @(negedge clk);
    data = dataOut;
    nextDrivePoint();
    readStrobe = 1'b0;
  endtask

  // status is polled every cycle so no read edge clears done before it is seen
  task automatic waitForDone(input string testName);
    byte_t status;
    logic  sawBusy;
    logic  finished;
    sawBusy    = 1'b0;
    finished   = 1'b0;
    portId     = `RTC_PORT_STATUS;
    readStrobe = 1'b1;
    while (!finished) begin
      @(negedge clk);
      status   = dataOut;
      sawBusy  = sawBusy | status[STAT_BUSY_BIT];
      finished = status[STAT_DONE_BIT];
      nextDrivePoint();
    end
    readStrobe = 1'b0;
    checkValue({testName, " busy seen"}, 8'h01, {7'h0, sawBusy});
    checkValue({testName, " busy after done"}, 8'h00, {7'h0, status[STAT_BUSY_BIT]});
    repeat (3) nextDrivePoint();
    readPort(`RTC_PORT_STATUS, status);
    checkValue({testName, " done cleared"}, 8'h00, {7'h0, status[STAT_DONE_BIT]});
  endtask

  task automatic loadTestData();
    int         fd;
    int         code;
    string      line;
    logic [7:0] op;
    byte_t      addr;
    byte_t      value;
    byte_t      expected;
    fd = $fopen("tb/rtcSubsystem_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      $display("Regression failed");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 2 && line.getc(0) != "#") begin
        code = $sscanf(line, "%c %h %h %h", op, addr, value, expected);
        if (code == 4) begin
          opQ.push_back(op);
          addrQ.push_back(addr);
          valueQ.push_back(value);
          expectQ.push_back(expected);
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    wait (cycleLimit > 0);
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout after %0d clock cycles without a result", cycleLimit);
    $display("Regression failed");
    $fatal(1);
  end

  initial begin
    string name;
    byte_t data;
    byte_t snapshot [0:127];
    int    n;
    int    i;
    int    idle;
    int    irqBit;
    rst         = 1'b1;
    readStrobe  = 1'b0;
    writeStrobe = 1'b0;
    portId      = '0;
    dataIn      = '0;
    irq         = 1'b0;
    loadTestData();
    cycleLimit = opQ.size() * (4 * `RTC_PHASE_CYCLES + 40);
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    checkValue("reset strobes", 8'h0f, {4'h0, adN, csN, rdN, wrN});
    checkValue("reset busOe", 8'h00, {7'h0, busOe});
    readPort(`RTC_PORT_STATUS, data);
    checkValue("reset status", 8'h00, data);

    for (n = 0; n < opQ.size(); n++) begin
      name = $sformatf("line %0d op %c addr %02h", n + 1, opQ[n], addrQ[n]);
      takeBits(3, idle);
      repeat (idle) nextDrivePoint();
      writePort(`RTC_PORT_ADDR, addrQ[n]); // address goes first since it selects the limit
      case (opQ[n])
        "W": begin
          writePort(`RTC_PORT_WDATA, valueQ[n]);
          writePort(`RTC_PORT_CTRL, START_WRITE);
          waitForDone(name);
          checkValue(name, expectQ[n], chip_i.regs[addrQ[n][6:0]]);
        end
        "R": begin
          writePort(`RTC_PORT_CTRL, START_READ);
          waitForDone(name);
          readPort(`RTC_PORT_RDATA, data);
          checkValue(name, expectQ[n], data);
        end
        "Z": begin
          for (i = 0; i < 128; i++) begin
            snapshot[i] = chip_i.regs[i];
          end
          writePort(`RTC_PORT_CTRL, START_READ);
          writePort(`RTC_PORT_WDATA, valueQ[n]);
          writePort(`RTC_PORT_CTRL, START_WRITE); // lands while the read runs
          waitForDone(name);
          readPort(`RTC_PORT_RDATA, data);
          checkValue(name, expectQ[n], data);
          for (i = 0; i < 128; i++) begin
            checkValue({name, " register untouched"}, snapshot[i], chip_i.regs[i]);
          end
        end
        default: begin
          $display("unknown operation on test data line %0d", n + 1);
          $display("Regression failed");
          $fatal(1);
        end
      endcase
    end

    // irq pin sampled into status with each value and its inverse
    for (n = 0; n < 3; n++) begin
      takeBits(1, irqBit);
      irq = irqBit[0];
      repeat (2) begin
        nextDrivePoint();
        readPort(`RTC_PORT_STATUS, data);
        checkValue("irq status", {7'h0, irq}, {7'h0, data[STAT_IRQ_BIT]});
        irq = ~irq;
      end
    end

    if (opQ.size() > 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("the test data file held no operations");
      $display("Regression failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// File: tb/rtcSubsystem_testdata.txt
# op addr value expected, all hex; Z = read with a write start issued while busy
# W expects the chip register after the write, R and Z the read-back byte
W 10 a5 a5
R 10 00 a5
W 7f 3c 3c
R 7f 00 3c
W 00 ff ff
R 00 00 ff
W 41 05 54
R 41 00 05
W 42 37 22
R 42 00 37
W 43 05 18
R 43 00 05
W 43 23 00
R 43 00 23
W 41 00 59
R 41 00 00
Z 10 77 a5
R 10 00 a5
Z 41 11 00
R 41 00 00
W 20 12 12
W 21 34 34
R 20 00 12
R 21 00 34
W 42 59 00
R 42 00 59

// File: rtcSubsystem.f
+incdir+include
rtl/rtcCpuPortPkg.sv
rtl/rtcBusPkg.sv
rtl/bcdComplement.sv
rtl/rtcBusSequencer.sv
rtl/rtcPort.sv
rtl/rtcSubsystem.sv
tb/rtcChipModel.sv
tb/rtcSubsystem_sva.sv
tb/rtcSubsystem_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module rtcSubsystem_tb -f rtcSubsystem.f -o simv || exit 1
out=$(./obj_dir/simv 2>&1)
echo "$out"
echo "$out" | grep -qx "Regression passed" && exit 0 || exit 1
